// ==== dnc_pkg.sv ====
// DNC interface gate definitions
// Fixed-point word format, PLAN sigmoid constants and the Q7.8 union view

package dnc_pkg;

  ////////////////////////////////////////
  // Word format
  ////////////////////////////////////////

  // Raw gates are signed Q7.8 and results are unsigned Q8.8
  localparam int word_width = 16;
  localparam int frac_width = 8;

  // 1.0 in Q8.8
  localparam logic [word_width-1:0] gate_one = word_width'(1 << frac_width);

  ////////////////////////////////////////
  // PLAN approximation
  ////////////////////////////////////////

  // Segment offsets in Q8.8, 0.5 / 0.625 / 0.84375
  localparam logic [word_width-1:0] plan_half        = 16'd128;
  localparam logic [word_width-1:0] plan_seg1_offset = 16'd160;
  localparam logic [word_width-1:0] plan_seg2_offset = 16'd216;

  // Breakpoints on |x| in Q7.8, 5.0 / 2.375 / 1.0
  localparam logic [word_width-1:0] plan_x_sat  = 16'd1280;
  localparam logic [word_width-1:0] plan_x_seg2 = 16'd608;
  localparam logic [word_width-1:0] plan_x_seg1 = 16'd256;

  // One Q7.8 word, as a number or as its bit fields
  typedef union packed {
    logic signed [word_width-1:0] raw;
    struct packed {
      logic                             sign;
      logic [word_width-frac_width-2:0] int_part;
      logic [frac_width-1:0]            frac_part;
    } fields;
  } dnc_fixed_t;

endpackage

// ==== dnc_scalar_logistic.sv ====
// Scalar logistic unit
// Two-stage PLAN sigmoid, one signed Q7.8 operand per cycle in,
// unsigned Q8.8 result out two cycles later

module dnc_scalar_logistic (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             in_valid,
  input  logic [dnc_pkg::word_width-1:0]   x_in,
  output logic                             out_valid,
  output logic [dnc_pkg::word_width-1:0]   y_out
);

  // Segment codes
  localparam logic [1:0] seg_zero = 2'd0;
  localparam logic [1:0] seg_one  = 2'd1;
  localparam logic [1:0] seg_two  = 2'd2;
  localparam logic [1:0] seg_sat  = 2'd3;

  dnc_pkg::dnc_fixed_t x_u;

  logic                            x_min;
  logic [dnc_pkg::word_width-1:0]  mag;
  logic [1:0]                      seg;

  // Stage one registers
  logic                            s1_valid;
  logic                            s1_neg;
  logic [1:0]                      s1_seg;
  logic [dnc_pkg::word_width-1:0]  s1_mag;

  // Stage two combinational result
  logic [dnc_pkg::word_width-1:0]  pos;
  logic [dnc_pkg::word_width-1:0]  y_next;

  ////////////////////////////////////////
  // Stage one, magnitude and segment
  ////////////////////////////////////////

  assign x_u = x_in;

  // Most negative word has no positive twin
  assign x_min = x_u.fields.sign && (x_u.fields.int_part == '0) &&
                 (x_u.fields.frac_part == '0);

  always_comb begin
    if (x_min) begin
      mag = 16'h7fff;
    end else if (x_u.fields.sign) begin
      mag = -x_u.raw;
    end else begin
      mag = x_u.raw;
    end
  end

  // Pick the PLAN segment on |x|
  always_comb begin
    if (mag >= dnc_pkg::plan_x_sat) begin
      seg = seg_sat;
    end else if (mag >= dnc_pkg::plan_x_seg2) begin
      seg = seg_two;
    end else if (mag >= dnc_pkg::plan_x_seg1) begin
      seg = seg_one;
    end else begin
      seg = seg_zero;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  // Payload only moves with a valid operand
  always_ff @(posedge clk) begin
    if (in_valid) begin
      s1_neg <= x_u.fields.sign;
      s1_seg <= seg;
      s1_mag <= mag;
    end
  end

  ////////////////////////////////////////
  // Stage two, shift and add
  ////////////////////////////////////////

  always_comb begin
    case (s1_seg)
      seg_sat: pos = dnc_pkg::gate_one;
      seg_two: pos = (s1_mag >> 5) + dnc_pkg::plan_seg2_offset;
      seg_one: pos = (s1_mag >> 3) + dnc_pkg::plan_seg1_offset;
      default: pos = (s1_mag >> 2) + dnc_pkg::plan_half;
    endcase
    // sigmoid(-x) = 1 - sigmoid(x)
    y_next = s1_neg ? (dnc_pkg::gate_one - pos) : pos;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      y_out <= y_next;
    end
  end

  // Result stays inside [0, 1.0]
  a_y_in_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid |-> (y_out <= dnc_pkg::gate_one)
  );

endmodule

// ==== dnc_gate_bank.sv ====
// Gate operand and result bank
// Captures all raw gate words on load, serves one operand per index
// and collects the sigmoid results one word per write

module dnc_gate_bank #(
  parameter int num_read_heads = 4
) (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  logic                                            load,
  input  logic [dnc_pkg::word_width-1:0]                  gw_in,
  input  logic [dnc_pkg::word_width-1:0]                  ga_in,
  input  logic [num_read_heads*dnc_pkg::word_width-1:0]   free_in,
  input  logic [$clog2(num_read_heads+2)-1:0]             rd_index,
  output logic [dnc_pkg::word_width-1:0]                  operand,
  input  logic                                            wr_en,
  input  logic [$clog2(num_read_heads+2)-1:0]             wr_index,
  input  logic [dnc_pkg::word_width-1:0]                  wr_data,
  output logic [dnc_pkg::word_width-1:0]                  gw_out,
  output logic [dnc_pkg::word_width-1:0]                  ga_out,
  output logic [num_read_heads*dnc_pkg::word_width-1:0]   free_out
);

  // Write gate, allocation gate, then one free gate per head
  localparam int num_gates = num_read_heads + 2;

  logic [dnc_pkg::word_width-1:0] raw_q [num_gates];
  logic [dnc_pkg::word_width-1:0] res_q [num_gates];

  ////////////////////////////////////////
  // Raw operands
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (load) begin
      raw_q[0] <= gw_in;
      raw_q[1] <= ga_in;
      for (int h = 0; h < num_read_heads; h++) begin
        raw_q[h+2] <= free_in[h*dnc_pkg::word_width +: dnc_pkg::word_width];
      end
    end
  end

  // Operand for the logistic unit
  assign operand = raw_q[rd_index];

  ////////////////////////////////////////
  // Results
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int g = 0; g < num_gates; g++) begin
        res_q[g] <= '0;
      end
    end else if (wr_en) begin
      res_q[wr_index] <= wr_data;
    end
  end

  assign gw_out = res_q[0];
  assign ga_out = res_q[1];

  // Free gates packed with head 0 in the low word
  always_comb begin
    for (int h = 0; h < num_read_heads; h++) begin
      free_out[h*dnc_pkg::word_width +: dnc_pkg::word_width] = res_q[h+2];
    end
  end

  // Controller never writes past the last gate
  a_wr_index_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_en |-> (int'(wr_index) < num_gates)
  );

endmodule

// ==== dnc_gate_control.sv ====
// Gate sequencer
// Start/ready control, issues one operand per cycle to the logistic unit
// and counts the returning results into the bank

module dnc_gate_control #(
  parameter int num_read_heads = 4
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 start,
  output logic                                 ready,
  output logic                                 done,
  output logic                                 load,
  output logic                                 issue_valid,
  output logic [$clog2(num_read_heads+2)-1:0]  rd_index,
  input  logic                                 out_valid,
  output logic                                 wr_en,
  output logic [$clog2(num_read_heads+2)-1:0]  wr_index
);

  localparam int idx_width = $clog2(num_read_heads + 2);

  // Index of the last free gate
  localparam logic [idx_width-1:0] last_index = idx_width'(num_read_heads + 1);

  // FSM states
  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_issue = 2'd1;
  localparam logic [1:0] st_drain = 2'd2;

  logic [1:0]           state_q;
  logic [idx_width-1:0] iss_cnt_q;
  logic [idx_width-1:0] wr_cnt_q;

  ////////////////////////////////////////
  // Strobes and indices
  ////////////////////////////////////////

  assign ready       = (state_q == st_idle);
  // Bank captures inputs on the accepted start edge
  assign load        = start && ready;
  assign issue_valid = (state_q == st_issue);
  assign rd_index    = iss_cnt_q;

  // Results only land while a run is active
  assign wr_en    = out_valid && !ready;
  assign wr_index = wr_cnt_q;

  // Last result written
  assign done = (state_q == st_drain) && out_valid && (wr_cnt_q == last_index);

  ////////////////////////////////////////
  // FSM and counters
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= st_idle;
      iss_cnt_q <= '0;
      wr_cnt_q  <= '0;
    end else begin
      case (state_q)
        st_idle: begin
          if (start) begin
            state_q   <= st_issue;
            iss_cnt_q <= '0;
            wr_cnt_q  <= '0;
          end
        end
        st_issue: begin
          // One operand per cycle, hold on the last one
          if (iss_cnt_q == last_index) begin
            state_q <= st_drain;
          end else begin
            iss_cnt_q <= iss_cnt_q + 1'b1;
          end
        end
        st_drain: begin
          // Wait for the pipeline to empty
          if (done) begin
            state_q <= st_idle;
          end
        end
        default: begin
          state_q <= st_idle;
        end
      endcase

      // Results may return while still issuing
      if (wr_en && !done) begin
        wr_cnt_q <= wr_cnt_q + 1'b1;
      end
    end
  end

  // Results only come back during a run
  a_no_result_when_ready: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid |-> !ready
  );

endmodule

// ==== dnc_interface_gates.sv ====
// DNC interface vector gates
// Write, allocation and free gates through one shared PLAN sigmoid
// under a start/ready handshake

module dnc_interface_gates #(
  parameter int num_read_heads = 4
) (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  logic                                            start,
  output logic                                            ready,
  output logic                                            done,
  input  logic [dnc_pkg::word_width-1:0]                  gw_in,
  input  logic [dnc_pkg::word_width-1:0]                  ga_in,
  input  logic [num_read_heads*dnc_pkg::word_width-1:0]   free_in,
  output logic [dnc_pkg::word_width-1:0]                  gw_out,
  output logic [dnc_pkg::word_width-1:0]                  ga_out,
  output logic [num_read_heads*dnc_pkg::word_width-1:0]   free_out
);

  localparam int idx_width = $clog2(num_read_heads + 2);

  ////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////

  // Controller to bank
  logic                           load;
  logic [idx_width-1:0]           rd_index;
  logic                           wr_en;
  logic [idx_width-1:0]           wr_index;

  // Logistic datapath
  logic                           issue_valid;
  logic [dnc_pkg::word_width-1:0] operand;
  logic                           out_valid;
  logic [dnc_pkg::word_width-1:0] y_out;

  ////////////////////////////////////////
  // Instances
  ////////////////////////////////////////

  dnc_gate_control #(
    .num_read_heads (num_read_heads)
  ) u_control (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .ready       (ready),
    .done        (done),
    .load        (load),
    .issue_valid (issue_valid),
    .rd_index    (rd_index),
    .out_valid   (out_valid),
    .wr_en       (wr_en),
    .wr_index    (wr_index)
  );

  dnc_gate_bank #(
    .num_read_heads (num_read_heads)
  ) u_bank (
    .clk      (clk),
    .rst_n    (rst_n),
    .load     (load),
    .gw_in    (gw_in),
    .ga_in    (ga_in),
    .free_in  (free_in),
    .rd_index (rd_index),
    .operand  (operand),
    .wr_en    (wr_en),
    .wr_index (wr_index),
    .wr_data  (y_out),
    .gw_out   (gw_out),
    .ga_out   (ga_out),
    .free_out (free_out)
  );

  // Shared sigmoid for every gate
  dnc_scalar_logistic u_logistic (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (issue_valid),
    .x_in      (operand),
    .out_valid (out_valid),
    .y_out     (y_out)
  );

endmodule

// ==== tb_dnc_interface_gates.sv ====
// Testbench for the DNC interface gates
// Directed and LFSR random gate words, checked against a PLAN sigmoid model

module tb_dnc_interface_gates;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_read_heads = 4;
  localparam int num_gates      = num_read_heads + 2;
  localparam int ww             = dnc_pkg::word_width;
  localparam int latency        = num_read_heads + 4;
  localparam int half_period    = 20;

  // Test lengths in transactions
  localparam int dir_txns    = 3;
  localparam int rand_txns   = 200;
  localparam int busy_txns   = 2;
  localparam int num_txns    = dir_txns + rand_txns + busy_txns;
  localparam int hold_cycles = 2 * latency;

  // One transaction is num_read_heads+6 cycles start to start
  localparam int watchdog_cycles =
    num_txns * (num_read_heads + 6) + busy_txns * hold_cycles + 20;

  localparam logic [31:0] lfsr_seed = 32'h3332_b679;
  localparam logic [31:0] lfsr_poly = 32'h8020_0003;

  logic                       clk;
  logic                       rst_n;
  logic                       start;
  logic                       ready;
  logic                       done;
  logic [ww-1:0]              gw_in;
  logic [ww-1:0]              ga_in;
  logic [num_read_heads*ww-1:0] free_in;
  logic [ww-1:0]              gw_out;
  logic [ww-1:0]              ga_out;
  logic [num_read_heads*ww-1:0] free_out;

  logic [31:0]   lfsr_state;
  int            error_cnt = 0;
  int            check_cnt = 0;
  int            run_cnt   = 0;
  int            run_bad   = 0;
  logic [ww-1:0] exp_q [$];
  logic [ww-1:0] op_words [num_gates];
  logic [ww-1:0] last_exp [num_gates];
  logic [ww-1:0] dir_words [dir_txns*num_gates];

  dnc_interface_gates #(
    .num_read_heads (num_read_heads)
  ) u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .ready    (ready),
    .done     (done),
    .gw_in    (gw_in),
    .ga_in    (ga_in),
    .free_in  (free_in),
    .gw_out   (gw_out),
    .ga_out   (ga_out),
    .free_out (free_out)
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // Galois LFSR, one step per bit taken
  function automatic logic take_bit();
    logic out_bit;
    out_bit    = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit) begin
      lfsr_state = lfsr_state ^ lfsr_poly;
    end
    return out_bit;
  endfunction

  // Half the words narrowed to +-8.0 so every segment is hit
  function automatic logic [ww-1:0] random_word();
    logic          narrow;
    logic [ww-1:0] w;
    int            i;
    narrow = take_bit();
    for (i = 0; i < ww; i++) begin
      w[i] = take_bit();
    end
    if (narrow) begin
      w = {{4{w[11]}}, w[11:0]};
    end
    return w;
  endfunction

  function automatic logic [ww-1:0] make_fixed(
    input logic                              sign,
    input logic [ww-dnc_pkg::frac_width-2:0] int_part,
    input logic [dnc_pkg::frac_width-1:0]    frac_part
  );
    dnc_pkg::dnc_fixed_t v;
    v.fields.sign      = sign;
    v.fields.int_part  = int_part;
    v.fields.frac_part = frac_part;
    return v.raw;
  endfunction

  // PLAN sigmoid model, Q7.8 in, Q8.8 out
  function automatic logic [ww-1:0] plan_sigmoid(input logic [ww-1:0] x);
    int xs;
    int mag;
    int pos;
    xs  = int'($signed(x));
    mag = (xs < 0) ? -xs : xs;
    // -128.0 clips to the largest magnitude
    if (mag > 32767) begin
      mag = 32767;
    end
    if (mag >= 1280) begin
      pos = 256;
    end else if (mag >= 608) begin
      pos = (mag >> 5) + 216;
    end else if (mag >= 256) begin
      pos = (mag >> 3) + 160;
    end else begin
      pos = (mag >> 2) + 128;
    end
    if (xs < 0) begin
      pos = 256 - pos;
    end
    return ww'(pos);
  endfunction

  function automatic string gate_name(input int g);
    string s;
    if (g == 0) begin
      s = "gw_out";
    end else if (g == 1) begin
      s = "ga_out";
    end else begin
      s = $sformatf("free_out[%0d]", g - 2);
    end
    return s;
  endfunction

  function automatic logic [ww-1:0] out_word(input int g);
    logic [ww-1:0] w;
    if (g == 0) begin
      w = gw_out;
    end else if (g == 1) begin
      w = ga_out;
    end else begin
      w = free_out[(g-2)*ww +: ww];
    end
    return w;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_cnt++;
    if (actual !== expected) begin
      error_cnt++;
      $display("[ERROR] %0t %s expected %0h got %0h", $time, name, expected, actual);
    end
  endtask

  task automatic finish_run();
    $display("checks %0d, errors %0d", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  task automatic end_test(input string name, input int mark);
    // Let the last comparison land first
    @(posedge clk);
    $display("test %s: %0d errors", name, error_cnt - mark);
  endtask

  task automatic drive_words();
    gw_in <= op_words[0];
    ga_in <= op_words[1];
    for (int h = 0; h < num_read_heads; h++) begin
      free_in[h*ww +: ww] <= op_words[h+2];
    end
  endtask

  // Breakpoints, their neighbours and saturation
  task automatic fill_directed();
    logic [ww-1:0] one_p;
    logic [ww-1:0] seg2_p;
    logic [ww-1:0] sat_p;
    one_p         = make_fixed(1'b0, 7'd1, 8'h00);
    seg2_p        = make_fixed(1'b0, 7'd2, 8'h60);
    sat_p         = make_fixed(1'b0, 7'd5, 8'h00);
    dir_words[0]  = '0;
    dir_words[1]  = one_p;
    dir_words[2]  = -one_p;
    dir_words[3]  = seg2_p;
    dir_words[4]  = -seg2_p;
    dir_words[5]  = sat_p;
    dir_words[6]  = -sat_p;
    dir_words[7]  = make_fixed(1'b0, 7'h7f, 8'hff);
    dir_words[8]  = make_fixed(1'b1, 7'h00, 8'h00);
    dir_words[9]  = one_p - 16'd1;
    dir_words[10] = seg2_p - 16'd1;
    dir_words[11] = sat_p - 16'd1;
    dir_words[12] = -(one_p - 16'd1);
    dir_words[13] = -(seg2_p - 16'd1);
    dir_words[14] = -(sat_p - 16'd1);
    dir_words[15] = 16'h0001;
    dir_words[16] = 16'hffff;
    dir_words[17] = make_fixed(1'b1, 7'h40, 8'h00);
  endtask

  // One start/done run, optionally disturbed while busy
  task automatic apply_run(input bit disturb);
    int wait_cycles;
    for (int g = 0; g < num_gates; g++) begin
      last_exp[g] = plan_sigmoid(op_words[g]);
      exp_q.push_back(last_exp[g]);
    end
    @(posedge clk);
    drive_words();
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    if (disturb) begin
      // Fresh inputs after the load edge must not leak in
      for (int g = 0; g < num_gates; g++) begin
        op_words[g] = random_word();
      end
      @(posedge clk);
      drive_words();
      @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
    end
    wait_cycles = 0;
    do begin
      @(negedge clk);
      wait_cycles++;
    end while (!done && wait_cycles < 2 * latency);
    if (!done) begin
      $display("timeout, done did not arrive within %0d cycles", 2 * latency);
      error_cnt++;
      finish_run();
    end else begin
      // Last result written on this edge
      @(posedge clk);
    end
  endtask

  // Idle outputs keep the last results while the inputs wander
  task automatic hold_outputs();
    repeat (hold_cycles) begin
      @(posedge clk);
      for (int g = 0; g < num_gates; g++) begin
        op_words[g] = random_word();
      end
      drive_words();
      @(negedge clk);
      for (int g = 0; g < num_gates; g++) begin
        check_value(gate_name(g), last_exp[g], out_word(g));
      end
    end
  endtask

  ////////////////////////////////////////
  // Clock and watchdog
  ////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not finish", watchdog_cycles);
    $display("Errors found");
    $finish;
  end

  ////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////

  initial begin : compare_proc
    logic [ww-1:0] exp_words [num_gates];
    bit            run_active;
    int            run_cycles;
    run_active = 1'b0;
    run_cycles = 0;
    forever begin
      @(negedge clk);
      if (run_active) begin
        run_cycles++;
        if (ready || (done && run_cycles != latency)) begin
          run_bad++;
        end
        check_value("ready", 32'd0, ready);
        if (done) begin
          check_value("done latency cycles", latency, run_cycles);
          run_active = 1'b0;
          run_cnt++;
          // Results settle after the done edge
          @(negedge clk);
          // done is a single pulse and ready returns right after it
          check_value("done", 32'd0, done);
          check_value("ready", 32'd1, ready);
          if (exp_q.size() < num_gates) begin
            $display("results at %0t arrived with no expected values queued", $time);
            error_cnt++;
          end else begin
            for (int g = 0; g < num_gates; g++) begin
              exp_words[g] = exp_q.pop_front();
              check_value(gate_name(g), exp_words[g], out_word(g));
            end
          end
        end
      end else if (done) begin
        $display("done pulsed at %0t with no accepted start", $time);
        error_cnt++;
      end
      // Start seen here is taken on the next rising edge
      if (!run_active && start && ready) begin
        run_active = 1'b1;
        run_cycles = 0;
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin : stimulus
    int mark;
    rst_n      = 1'b0;
    start      = 1'b0;
    gw_in      = '0;
    ga_in      = '0;
    free_in    = '0;
    lfsr_state = lfsr_seed;

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // Reset state
    mark = error_cnt;
    @(negedge clk);
    check_value("ready", 32'd1, ready);
    check_value("done", 32'd0, done);
    for (int g = 0; g < num_gates; g++) begin
      check_value(gate_name(g), 32'd0, out_word(g));
    end
    end_test("reset", mark);

    mark = error_cnt;
    fill_directed();
    for (int t = 0; t < dir_txns; t++) begin
      for (int g = 0; g < num_gates; g++) begin
        op_words[g] = dir_words[t*num_gates+g];
      end
      apply_run(1'b0);
    end
    end_test("directed", mark);

    mark = error_cnt;
    for (int t = 0; t < rand_txns; t++) begin
      for (int g = 0; g < num_gates; g++) begin
        op_words[g] = random_word();
      end
      apply_run(1'b0);
    end
    end_test("random", mark);

    // Busy start, late input changes, then idle hold
    mark = error_cnt;
    for (int t = 0; t < busy_txns; t++) begin
      for (int g = 0; g < num_gates; g++) begin
        op_words[g] = random_word();
      end
      apply_run(1'b1);
      hold_outputs();
    end
    end_test("busy start and hold", mark);

    $display("test latency: %0d runs timed, %0d errors", run_cnt, run_bad);
    finish_run();
  end

endmodule

// ==== project.f ====
dnc_pkg.sv
dnc_scalar_logistic.sv
dnc_gate_bank.sv
dnc_gate_control.sv
dnc_interface_gates.sv
tb_dnc_interface_gates.sv

// ==== Bender.yml ====
package:
  name: dnc_interface_gates

sources:
  - dnc_pkg.sv
  - dnc_scalar_logistic.sv
  - dnc_gate_bank.sv
  - dnc_gate_control.sv
  - dnc_interface_gates.sv
  - target: test
    files:
      - tb_dnc_interface_gates.sv
